//--- cache_to_dram_tx.f
rtl/dram_tx_geom_pkg.sv
rtl/dram_tx_types_pkg.sv
rtl/small_fifo.sv
rtl/beat_packer.sv
rtl/cache_lane.sv
rtl/async_word_fifo.sv
rtl/dram_tx_merge.sv
rtl/cache_to_dram_tx.sv
tests/cache_to_dram_tx_tb.sv

//--- rtl/async_word_fifo.sv
`timescale 1ns/1ps

module async_word_fifo #(
  parameter int lg_size_p = 3
  , parameter int width_p = 128
) (
  input w_clk_i
  , input w_rst_i
  , input w_enq_i
  , input [width_p-1:0] w_data_i
  , output logic w_full_o
  , input r_clk_i
  , input r_rst_i
  , input r_deq_i
  , output logic [width_p-1:0] r_data_o
  , output logic r_valid_o
);

  localparam int size_lp = 1 << lg_size_p;

  logic [width_p-1:0] mem_r [size_lp];

  // Pointers carry one extra wrap bit.
  logic [lg_size_p:0] w_bin_r;
  logic [lg_size_p:0] w_gray_r;
  logic [lg_size_p:0] w_bin_n;
  logic [lg_size_p:0] r_bin_r;
  logic [lg_size_p:0] r_gray_r;
  logic [lg_size_p:0] r_bin_n;
  logic [lg_size_p:0] r_gray_meta_r;
  logic [lg_size_p:0] r_gray_sync_r;
  logic [lg_size_p:0] w_gray_meta_r;
  logic [lg_size_p:0] w_gray_sync_r;
  logic w_enq;
  logic r_deq;

  assign w_enq = w_enq_i & ~w_full_o;
  assign w_bin_n = w_bin_r + 1'b1;

  // Full when the pointers differ only in the two top Gray bits.
  assign w_full_o = (w_gray_r == {~r_gray_sync_r[lg_size_p:lg_size_p-1],
                                  r_gray_sync_r[lg_size_p-2:0]});

  always_ff @(posedge w_clk_i) begin
    if (w_rst_i) begin
      w_bin_r <= '0;
      w_gray_r <= '0;
      r_gray_meta_r <= '0;
      r_gray_sync_r <= '0;
    end else begin
      if (w_enq) begin
        w_bin_r <= w_bin_n;
        w_gray_r <= w_bin_n ^ (w_bin_n >> 1);
      end
      r_gray_meta_r <= r_gray_r;
      r_gray_sync_r <= r_gray_meta_r;
    end
  end

  always_ff @(posedge w_clk_i) begin
    if (w_enq) begin
      mem_r[w_bin_r[lg_size_p-1:0]] <= w_data_i;
    end
  end

  assign r_valid_o = (r_gray_r != w_gray_sync_r);
  assign r_deq = r_deq_i & r_valid_o;
  assign r_bin_n = r_bin_r + 1'b1;
  assign r_data_o = mem_r[r_bin_r[lg_size_p-1:0]];

  always_ff @(posedge r_clk_i) begin
    if (r_rst_i) begin
      r_bin_r <= '0;
      r_gray_r <= '0;
      w_gray_meta_r <= '0;
      w_gray_sync_r <= '0;
    end else begin
      if (r_deq) begin
        r_bin_r <= r_bin_n;
        r_gray_r <= r_bin_n ^ (r_bin_n >> 1);
      end
      w_gray_meta_r <= w_gray_r;
      w_gray_sync_r <= w_gray_meta_r;
    end
  end

endmodule

//--- rtl/beat_packer.sv
`timescale 1ns/1ps

module beat_packer
  import dram_tx_types_pkg::*;
#(
  parameter int dma_data_width_p = 32
  , parameter int dram_data_width_p = 128
) (
  input clk_i
  , input rst_i
  , input v_i
  , input dma_word_t data_i
  , output logic ready_o
  , output logic v_o
  , output dram_word_t data_o
  , input yumi_i
);

  localparam int beats_lp = dram_data_width_p / dma_data_width_p;
  localparam int cnt_width_lp = (beats_lp > 1) ? $clog2(beats_lp) : 1;
  localparam logic [cnt_width_lp-1:0] last_beat_lp = cnt_width_lp'(beats_lp - 1);

  logic [cnt_width_lp-1:0] cnt_r;
  logic full_r;
  dram_word_t word_r;
  dram_word_t word_n;
  logic take;

  assign take = v_i & ~full_r;
  assign ready_o = ~full_r;
  assign v_o = full_r;
  assign data_o = word_r;

  // New beats enter at the top, so the first one ends at the bottom.
  if (beats_lp == 1) begin : g_single
    assign word_n = dram_word_t'(data_i);
  end else begin : g_shift
    assign word_n = {data_i, word_r[dram_data_width_p-1:dma_data_width_p]};
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_r <= '0;
      full_r <= 1'b0;
    end else begin
      if (take) begin
        if (cnt_r == last_beat_lp) begin
          cnt_r <= '0;
          full_r <= 1'b1;
        end else begin
          cnt_r <= cnt_r + 1'b1;
        end
      end else if (yumi_i) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      word_r <= word_n;
    end
  end

endmodule

//--- rtl/cache_lane.sv
`timescale 1ns/1ps

module cache_lane
  import dram_tx_types_pkg::*;
#(
  parameter int data_width_p = 32
  , parameter int block_size_in_words_p = 8
  , parameter int dma_data_width_p = 32
  , parameter int dram_data_width_p = 128
) (
  input clk_i
  , input rst_i
  , input dma_v_i
  , input dma_word_t dma_data_i
  , output logic dma_yumi_o
  , output logic v_o
  , output dram_word_t data_o
  , input yumi_i
);

  // Beats in one evicted block.
  localparam int block_beats_lp = block_size_in_words_p * data_width_p / dma_data_width_p;

  logic fifo_ready;
  logic fifo_v;
  dma_word_t fifo_data;
  logic packer_ready;

  small_fifo #(
    .payload_t(dma_word_t)
    , .els_p(block_beats_lp)
  ) block_fifo (
    .clk_i(clk_i)
    , .rst_i(rst_i)
    , .v_i(dma_v_i)
    , .data_i(dma_data_i)
    , .ready_o(fifo_ready)
    , .v_o(fifo_v)
    , .data_o(fifo_data)
    , .yumi_i(fifo_v & packer_ready)
  );

  assign dma_yumi_o = dma_v_i & fifo_ready;

  beat_packer #(
    .dma_data_width_p(dma_data_width_p)
    , .dram_data_width_p(dram_data_width_p)
  ) packer (
    .clk_i(clk_i)
    , .rst_i(rst_i)
    , .v_i(fifo_v)
    , .data_i(fifo_data)
    , .ready_o(packer_ready)
    , .v_o(v_o)
    , .data_o(data_o)
    , .yumi_i(yumi_i)
  );

endmodule

//--- rtl/cache_to_dram_tx.sv
`timescale 1ns/1ps

module cache_to_dram_tx
  import dram_tx_geom_pkg::*;
  import dram_tx_types_pkg::*;
#(
  parameter int num_cache_p = num_cache_c
  , parameter int dma_data_width_p = dma_data_width_c
  , parameter int dram_data_width_p = dram_data_width_c
  , parameter int block_size_in_words_p = block_size_in_words_c
  , parameter int data_width_p = data_width_c
) (
  input core_clk_i
  , input dram_clk_i
  , input rst_i
  , input v_i
  , input cache_id_t tag_i
  , output logic ready_o
  , input dma_word_t [num_cache_p-1:0] dma_data_i
  , input [num_cache_p-1:0] dma_data_v_i
  , output logic [num_cache_p-1:0] dma_data_yumi_o
  , output logic dram_data_v_o
  , output dram_word_t dram_data_o
  , input dram_data_yumi_i
);

  // One tag slot per packed word of every cache.
  localparam int num_req_lp = block_size_in_words_p * data_width_p / dram_data_width_p;

  logic tag_v;
  cache_id_t tag_head;
  logic tag_yumi;
  logic [num_cache_p-1:0] lane_v;
  dram_word_t [num_cache_p-1:0] lane_data;
  logic [num_cache_p-1:0] lane_yumi;

  small_fifo #(
    .payload_t(cache_id_t)
    , .els_p(num_cache_p * num_req_lp)
  ) tag_fifo (
    .clk_i(core_clk_i)
    , .rst_i(rst_i)
    , .v_i(v_i)
    , .data_i(tag_i)
    , .ready_o(ready_o)
    , .v_o(tag_v)
    , .data_o(tag_head)
    , .yumi_i(tag_yumi)
  );

  for (genvar i = 0; i < num_cache_p; i++) begin : g_lane
    cache_lane #(
      .data_width_p(data_width_p)
      , .block_size_in_words_p(block_size_in_words_p)
      , .dma_data_width_p(dma_data_width_p)
      , .dram_data_width_p(dram_data_width_p)
    ) lane (
      .clk_i(core_clk_i)
      , .rst_i(rst_i)
      , .dma_v_i(dma_data_v_i[i])
      , .dma_data_i(dma_data_i[i])
      , .dma_yumi_o(dma_data_yumi_o[i])
      , .v_o(lane_v[i])
      , .data_o(lane_data[i])
      , .yumi_i(lane_yumi[i])
    );
  end

  dram_tx_merge #(
    .num_cache_p(num_cache_p)
    , .data_width_p(data_width_p)
    , .block_size_in_words_p(block_size_in_words_p)
    , .dram_data_width_p(dram_data_width_p)
  ) merge (
    .core_clk_i(core_clk_i)
    , .dram_clk_i(dram_clk_i)
    , .rst_i(rst_i)
    , .tag_v_i(tag_v)
    , .tag_i(tag_head)
    , .tag_yumi_o(tag_yumi)
    , .lane_v_i(lane_v)
    , .lane_data_i(lane_data)
    , .lane_yumi_o(lane_yumi)
    , .dram_data_v_o(dram_data_v_o)
    , .dram_data_o(dram_data_o)
    , .dram_data_yumi_i(dram_data_yumi_i)
  );

endmodule

//--- rtl/dram_tx_geom_pkg.sv
package dram_tx_geom_pkg;

  // Default geometry of the write path.
  localparam int num_cache_c = 4;
  localparam int data_width_c = 32;
  localparam int block_size_in_words_c = 8;
  localparam int dma_data_width_c = 32;
  localparam int dram_data_width_c = 128;

  // DMA beats packed into one DRAM word.
  localparam int beats_per_word_c = dram_data_width_c / dma_data_width_c;

  // Width of a cache id, at least one bit.
  localparam int lg_num_cache_c = (num_cache_c > 1) ? $clog2(num_cache_c) : 1;

endpackage

//--- rtl/dram_tx_merge.sv
`timescale 1ns/1ps

module dram_tx_merge
  import dram_tx_types_pkg::*;
#(
  parameter int num_cache_p = 4
  , parameter int data_width_p = 32
  , parameter int block_size_in_words_p = 8
  , parameter int dram_data_width_p = 128
) (
  input core_clk_i
  , input dram_clk_i
  , input rst_i
  , input tag_v_i
  , input cache_id_t tag_i
  , output logic tag_yumi_o
  , input [num_cache_p-1:0] lane_v_i
  , input dram_word_t [num_cache_p-1:0] lane_data_i
  , output logic [num_cache_p-1:0] lane_yumi_o
  , output logic dram_data_v_o
  , output dram_word_t dram_data_o
  , input dram_data_yumi_i
);

  localparam int num_req_lp = block_size_in_words_p * data_width_p / dram_data_width_p;
  localparam int afifo_els_lp = (num_cache_p * num_req_lp > 4) ? num_cache_p * num_req_lp : 4;
  localparam int lg_afifo_size_lp = $clog2(afifo_els_lp);

  logic afifo_full;
  logic send;

  // Move a word only when the tag, its lane and FIFO space all line up.
  assign send = tag_v_i & lane_v_i[tag_i] & ~afifo_full;
  assign tag_yumi_o = send;

  for (genvar i = 0; i < num_cache_p; i++) begin : g_yumi
    assign lane_yumi_o[i] = send & (tag_i == cache_id_t'(i));
  end

  async_word_fifo #(
    .lg_size_p(lg_afifo_size_lp)
    , .width_p(dram_data_width_p)
  ) data_afifo (
    .w_clk_i(core_clk_i)
    , .w_rst_i(rst_i)
    , .w_enq_i(send)
    , .w_data_i(lane_data_i[tag_i])
    , .w_full_o(afifo_full)
    , .r_clk_i(dram_clk_i)
    , .r_rst_i(rst_i)
    , .r_deq_i(dram_data_yumi_i)
    , .r_data_o(dram_data_o)
    , .r_valid_o(dram_data_v_o)
  );

endmodule

//--- rtl/dram_tx_types_pkg.sv
package dram_tx_types_pkg;

  import dram_tx_geom_pkg::*;

  // Names one cache.
  typedef logic [lg_num_cache_c-1:0] cache_id_t;

  // One DMA beat.
  typedef logic [dma_data_width_c-1:0] dma_word_t;

  // One packed DRAM word.
  typedef logic [dram_data_width_c-1:0] dram_word_t;

endpackage

//--- rtl/small_fifo.sv
`timescale 1ns/1ps

module small_fifo #(
  parameter type payload_t = logic
  , parameter int els_p = 4
) (
  input clk_i
  , input rst_i
  , input v_i
  , input payload_t data_i
  , output logic ready_o
  , output logic v_o
  , output payload_t data_o
  , input yumi_i
);

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam logic [ptr_width_lp:0] full_count_lp = (ptr_width_lp + 1)'(els_p);
  localparam logic [ptr_width_lp-1:0] last_ptr_lp = ptr_width_lp'(els_p - 1);

  payload_t mem_r [els_p];
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp:0] count_r;
  logic [ptr_width_lp:0] count_n;
  logic ready_r;
  logic enq;
  logic deq;

  assign enq = v_i & ready_r;
  assign deq = yumi_i;
  assign ready_o = ready_r;
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  always_comb begin
    count_n = count_r;
    if (enq && !deq) begin
      count_n = count_r + 1'b1;
    end else if (deq && !enq) begin
      count_n = count_r - 1'b1;
    end
  end

  // Ready is registered so it stays low through reset.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r <= '0;
      ready_r <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_n;
      ready_r <= (count_n != full_count_lp);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --timescale 1ns/1ps --top-module cache_to_dram_tx_tb \
       -f cache_to_dram_tx.f -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tests/cache_to_dram_tx_tb.sv
`timescale 1ns/1ps

module cache_to_dram_tx_tb
  import dram_tx_geom_pkg::*;
  import dram_tx_types_pkg::*;
();

  localparam int block_beats_lp = block_size_in_words_c * data_width_c / dma_data_width_c;
  // Beats over all tests, scaled by the 14/10 clock ratio.
  localparam int total_beats_lp = 8 + 32 + 16 + 96;
  localparam int timeout_lp = total_beats_lp * 14 / 10 * 20 + 2000;

  logic core_clk_i;
  logic dram_clk_i;
  logic rst_i;
  logic v_i;
  cache_id_t tag_i;
  logic ready_o;
  dma_word_t [num_cache_c-1:0] dma_data_i;
  logic [num_cache_c-1:0] dma_data_v_i;
  logic [num_cache_c-1:0] dma_data_yumi_o;
  logic dram_data_v_o;
  dram_word_t dram_data_o;
  logic dram_data_yumi_i;

  // Per-cache model of beats and the packed words built from them.
  dma_word_t beat_mem [num_cache_c][128];
  dram_word_t word_mem [num_cache_c][32];
  int beat_wr [num_cache_c];
  int beat_rd [num_cache_c];
  int word_wr [num_cache_c];
  int word_rd [num_cache_c];
  dram_word_t exp_q [$];
  int tag_list [$];
  int errors;
  int tests_run;
  int gap_max;
  logic hold;
  logic ready_dropped;
  string cur_test;

  cache_to_dram_tx #(
    .num_cache_p(num_cache_c)
    , .dma_data_width_p(dma_data_width_c)
    , .dram_data_width_p(dram_data_width_c)
    , .block_size_in_words_p(block_size_in_words_c)
    , .data_width_p(data_width_c)
  ) cache_to_dram_tx_i (
    .core_clk_i(core_clk_i)
    , .dram_clk_i(dram_clk_i)
    , .rst_i(rst_i)
    , .v_i(v_i)
    , .tag_i(tag_i)
    , .ready_o(ready_o)
    , .dma_data_i(dma_data_i)
    , .dma_data_v_i(dma_data_v_i)
    , .dma_data_yumi_o(dma_data_yumi_o)
    , .dram_data_v_o(dram_data_v_o)
    , .dram_data_o(dram_data_o)
    , .dram_data_yumi_i(dram_data_yumi_i)
  );

  always #5 core_clk_i = ~core_clk_i;
  always #7 dram_clk_i = ~dram_clk_i;

  task automatic check_value(input string name, input dram_word_t expected,
                             input dram_word_t actual);
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic make_words(input int c, input int n);
    dram_word_t w;
    dma_word_t beat;
    for (int i = 0; i < n; i++) begin
      w = '0;
      for (int b = 0; b < beats_per_word_c; b++) begin
        beat = $urandom;
        beat_mem[c][beat_wr[c]] = beat;
        beat_wr[c]++;
        // Earlier beats land in lower bits.
        w[b*dma_data_width_c +: dma_data_width_c] = beat;
      end
      word_mem[c][word_wr[c]] = w;
      word_wr[c]++;
    end
  endtask

  task automatic make_tag_order(input int per_cache);
    int j;
    int t;
    tag_list.delete();
    for (int c = 0; c < num_cache_c; c++) begin
      for (int k = 0; k < per_cache; k++) begin
        tag_list.push_back(c);
      end
    end
    for (int i = tag_list.size() - 1; i > 0; i--) begin
      j = $urandom_range(i, 0);
      t = tag_list[i];
      tag_list[i] = tag_list[j];
      tag_list[j] = t;
    end
  endtask

  task automatic send_beats(input int c, input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge core_clk_i);
      dma_data_v_i[c] <= 1'b1;
      dma_data_i[c] <= beat_mem[c][beat_rd[c]];
      beat_rd[c]++;
      @(negedge core_clk_i);
      while (!dma_data_yumi_o[c]) @(negedge core_clk_i);
    end
    @(posedge core_clk_i);
    dma_data_v_i[c] <= 1'b0;
  endtask

  task automatic send_tags();
    int c;
    foreach (tag_list[i]) begin
      c = tag_list[i];
      @(posedge core_clk_i);
      v_i <= 1'b1;
      tag_i <= cache_id_t'(c);
      @(negedge core_clk_i);
      while (!ready_o) begin
        ready_dropped = 1'b1;
        @(negedge core_clk_i);
      end
      // Tag taken at the coming edge, so its word is next in line.
      exp_q.push_back(word_mem[c][word_rd[c]]);
      word_rd[c]++;
    end
    @(posedge core_clk_i);
    v_i <= 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(posedge core_clk_i);
    repeat (10) @(posedge core_clk_i);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("[PASS] %s", name);
    end else begin
      $display("[FAIL] %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset_idle();
    int e0;
    e0 = errors;
    cur_test = "reset_idle";
    @(posedge core_clk_i);
    dma_data_v_i[0] <= 1'b1;
    repeat (10) @(posedge dram_clk_i);
    @(negedge core_clk_i);
    check_value("reset_idle ready_o", '0, dram_word_t'(ready_o));
    check_value("reset_idle dma_data_yumi_o", '0, dram_word_t'(dma_data_yumi_o));
    check_value("reset_idle dram_data_v_o", '0, dram_word_t'(dram_data_v_o));
    @(posedge core_clk_i);
    dma_data_v_i[0] <= 1'b0;
    rst_i <= 1'b0;
    repeat (30) begin
      @(negedge core_clk_i);
      check_value("reset_idle dram_data_v_o", '0, dram_word_t'(dram_data_v_o));
    end
    check_value("reset_idle ready_o", dram_word_t'(1'b1), dram_word_t'(ready_o));
    finish_test(cur_test, e0);
  endtask

  task automatic test_single_block();
    int e0;
    e0 = errors;
    cur_test = "single_block";
    make_words(0, block_beats_lp / beats_per_word_c);
    tag_list.delete();
    for (int k = 0; k < block_beats_lp / beats_per_word_c; k++) begin
      tag_list.push_back(0);
    end
    fork
      send_beats(0, block_beats_lp);
      send_tags();
    join
    wait_drained();
    finish_test(cur_test, e0);
  endtask

  task automatic test_interleaved();
    int e0;
    e0 = errors;
    cur_test = "interleaved";
    gap_max = 2;
    for (int c = 0; c < num_cache_c; c++) begin
      make_words(c, block_beats_lp / beats_per_word_c);
      send_beats(c, block_beats_lp);
    end
    make_tag_order(block_beats_lp / beats_per_word_c);
    send_tags();
    wait_drained();
    gap_max = 0;
    finish_test(cur_test, e0);
  endtask

  task automatic test_tag_data_skew();
    int e0;
    e0 = errors;
    cur_test = "tag_data_skew";
    // Tags for cache 1 arrive well before its data.
    make_words(1, 2);
    tag_list.delete();
    tag_list.push_back(1);
    tag_list.push_back(1);
    send_tags();
    repeat (30) @(posedge core_clk_i);
    send_beats(1, block_beats_lp);
    wait_drained();
    // Data for cache 2 waits with no tag.
    make_words(2, 2);
    send_beats(2, block_beats_lp);
    repeat (50) @(posedge core_clk_i);
    @(negedge dram_clk_i);
    check_value("tag_data_skew dram_data_v_o", '0, dram_word_t'(dram_data_v_o));
    tag_list.delete();
    tag_list.push_back(2);
    tag_list.push_back(2);
    send_tags();
    wait_drained();
    finish_test(cur_test, e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    cur_test = "backpressure";
    ready_dropped = 1'b0;
    hold = 1'b1;
    gap_max = 8;
    for (int c = 0; c < num_cache_c; c++) begin
      make_words(c, 6);
    end
    make_tag_order(6);
    fork
      send_beats(0, 6 * beats_per_word_c);
      send_beats(1, 6 * beats_per_word_c);
      send_beats(2, 6 * beats_per_word_c);
      send_beats(3, 6 * beats_per_word_c);
      send_tags();
      begin
        for (int i = 0; i < 400 && !ready_dropped; i++) @(posedge core_clk_i);
        repeat (20) @(posedge core_clk_i);
        hold = 1'b0;
      end
    join
    check_value("backpressure ready_o dropped", dram_word_t'(1'b1),
                dram_word_t'(ready_dropped));
    wait_drained();
    gap_max = 0;
    finish_test(cur_test, e0);
  endtask

  // DRAM side collector, one word per two cycles at most.
  initial begin
    dram_word_t got;
    dram_data_yumi_i = 1'b0;
    forever begin
      @(negedge dram_clk_i);
      if (!rst_i && dram_data_v_o && !hold) begin
        if (gap_max > 0) begin
          repeat ($urandom_range(gap_max, 0)) @(negedge dram_clk_i);
        end
        got = dram_data_o;
        @(posedge dram_clk_i);
        dram_data_yumi_i <= 1'b1;
        @(posedge dram_clk_i);
        dram_data_yumi_i <= 1'b0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("DRAM word %0h came out with no tag pending in %s", got, cur_test);
        end else begin
          check_value(cur_test, exp_q.pop_front(), got);
        end
      end
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < timeout_lp) begin
      @(posedge core_clk_i);
      cycles++;
    end
    $display("Run stopped after %0d core cycles without finishing", timeout_lp);
    $display("Test failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h8b1a));
    core_clk_i = 1'b0;
    dram_clk_i = 1'b0;
    rst_i = 1'b1;
    v_i = 1'b0;
    tag_i = '0;
    dma_data_i = '0;
    dma_data_v_i = '0;
    hold = 1'b0;
    ready_dropped = 1'b0;
    gap_max = 0;
    errors = 0;
    tests_run = 0;
    test_reset_idle();
    test_single_block();
    test_interleaved();
    test_tag_data_skew();
    test_backpressure();
    $display("Summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
